/* sys_arr_pkg.sv */
package sys_arr_pkg;

    // Default operand width in bits.
    localparam int DW_DEF = 8;

    // Default array size; the grid is N_DEF by N_DEF cells.
    localparam int N_DEF = 4;

    // Default FIFO depth, counted in whole operand pairs.
    localparam int DEPTH_DEF = 2;

    // An accumulator must hold N products of two DW-bit operands.
    // Each product needs 2*DW bits and the sum of N of them adds ceil(log2 N) bits.
    function automatic int acc_width(input int dw, input int n);
        return 2 * dw + $clog2(n);
    endfunction

    // Controller sequence for one matrix product.
    // IDLE waits for a stored pair, SHIFT feeds the skewed operands,
    // DRAIN lets the last products reach the far corner, READOUT returns C.
    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        DRAIN,
        READOUT
    } ctrl_state_t;

endpackage

/* systolic_array_fifo_if.sv */
interface systolic_array_fifo_if import sys_arr_pkg::*; #(
    parameter int DW = DW_DEF,
    parameter int N  = N_DEF
);

    // Writes one whole row of N words into the FIFO.
    logic            load;

    // The row that load stores, word k in bits [k*DW +: DW].
    logic [N*DW-1:0] load_values;

    // Advances the FIFO by one word.
    logic            shift;

    // The word currently presented by the FIFO.
    logic [DW-1:0]   out;

    // High while the current row still holds words.
    logic            valid;

    // The FIFO side takes the commands and presents the word.
    modport fifo (input load, load_values, shift, output out, valid);

    // The controller issues load and shift and watches the flag.
    // load_values is driven straight from the input beat at the top level.
    modport ctrl (output load, shift, input out, valid);

endinterface

/* sysarr_fifo.sv */
module sysarr_fifo import sys_arr_pkg::*; #(
    parameter int DW    = DW_DEF,
    parameter int N     = N_DEF,
    parameter int DEPTH = DEPTH_DEF
) (
    input logic                 clk,
    input logic                 nRST,
    systolic_array_fifo_if.fifo fifo
);

    // Pointer widths, kept at least one bit wide.
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = (N > 1) ? $clog2(N) : 1;

    // Row storage, one full operand row per entry.
    logic [N*DW-1:0] mem [DEPTH];

    // One flag per row, set on load and cleared when its last word leaves.
    logic [DEPTH-1:0] row_vld;

    // Circular row pointers and the word pointer inside the read row.
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] col_ptr;

    logic do_shift;
    logic last_word;

    // Steps a row pointer around the ring of DEPTH entries.
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // The presented word is picked out of the read row by the column pointer.
    assign fifo.out   = mem[rd_ptr][col_ptr*DW +: DW];
    assign fifo.valid = row_vld[rd_ptr];

    // A shift with no valid row is dropped.
    assign do_shift  = fifo.shift && row_vld[rd_ptr];
    assign last_word = (col_ptr == CW'(N - 1));

    always_ff @(posedge clk) begin
        if (fifo.load) begin
            mem[wr_ptr] <= fifo.load_values;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            row_vld <= '0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            col_ptr <= '0;
        end else begin
            if (fifo.load) begin
                row_vld[wr_ptr] <= 1'b1;
                wr_ptr          <= next_ptr(wr_ptr);
            end
            if (do_shift) begin
                // The last word of a row frees that row and moves to the next one.
                if (last_word) begin
                    row_vld[rd_ptr] <= 1'b0;
                    rd_ptr          <= next_ptr(rd_ptr);
                    col_ptr         <= '0;
                end else begin
                    col_ptr <= col_ptr + 1'b1;
                end
            end
            // A load into an empty FIFO makes the new row the read row.
            if (fifo.load && !row_vld[rd_ptr]) begin
                rd_ptr  <= wr_ptr;
                col_ptr <= '0;
            end
        end
    end

endmodule

/* sysarr_pe.sv */
module sysarr_pe import sys_arr_pkg::*; #(
    parameter int DW    = DW_DEF,
    parameter int ACC_W = acc_width(DW_DEF, N_DEF)
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic             clear,
    input  logic [DW-1:0]    a_in,
    input  logic [DW-1:0]    b_in,
    input  logic             a_vld_in,
    input  logic             b_vld_in,
    output logic [DW-1:0]    a_out,
    output logic [DW-1:0]    b_out,
    output logic             a_vld_out,
    output logic [ACC_W-1:0] acc
);

    // Product of the registered operand pair.
    logic [2*DW-1:0] prod;

    // Both operand streams reach a cell in the same cycle.
    // One registered flag therefore marks the pair and travels right and down.
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            a_vld_out <= 1'b0;
        end else begin
            a_vld_out <= a_vld_in & b_vld_in;
        end
    end

    // Operands move one cell per cycle; the neighbors see these registers.
    always_ff @(posedge clk) begin
        a_out <= a_in;
        b_out <= b_in;
    end

    assign prod = a_out * b_out;

    // Output stationary: the sum stays here until the controller reads it.
    always_ff @(posedge clk) begin
        if (clear) begin
            acc <= '0;
        end else if (a_vld_out) begin
            acc <= acc + ACC_W'(prod);
        end
    end

endmodule

/* sysarr_array.sv */
module sysarr_array import sys_arr_pkg::*; #(
    parameter int  DW    = DW_DEF,
    parameter int  N     = N_DEF,
    localparam int ACC_W = acc_width(DW, N)
) (
    input  logic                             clk,
    input  logic                             nRST,
    input  logic                             clear,
    input  logic [N-1:0][DW-1:0]             a_edge,
    input  logic [N-1:0]                     a_edge_vld,
    input  logic [N-1:0][DW-1:0]             b_edge,
    input  logic [N-1:0]                     b_edge_vld,
    output logic [N-1:0][N-1:0][ACC_W-1:0]   acc_all
);

    // A data enters cell (i,j) on a_d[i][j]; column N is the far right output.
    logic [DW-1:0] a_d [N][N+1];
    // B data enters cell (i,j) on b_d[i][j]; row N is the bottom output.
    logic [DW-1:0] b_d [N+1][N];
    // Pair valid flags along the same two directions.
    logic          a_v [N][N+1];
    logic          b_v [N+1][N];

    // Row i of the grid is fed from A lane i at its left edge.
    for (genvar i = 0; i < N; i++) begin : g_left
        assign a_d[i][0] = a_edge[i];
        assign a_v[i][0] = a_edge_vld[i];
    end

    // Column j of the grid is fed from B lane j at its top edge.
    for (genvar j = 0; j < N; j++) begin : g_top
        assign b_d[0][j] = b_edge[j];
        assign b_v[0][j] = b_edge_vld[j];
    end

    for (genvar i = 0; i < N; i++) begin : g_row
        for (genvar j = 0; j < N; j++) begin : g_col
            sysarr_pe #(
                .DW   (DW),
                .ACC_W(ACC_W)
            ) u_pe (
                .clk      (clk),
                .nRST     (nRST),
                .clear    (clear),
                .a_in     (a_d[i][j]),
                .b_in     (b_d[i][j]),
                .a_vld_in (a_v[i][j]),
                .b_vld_in (b_v[i][j]),
                .a_out    (a_d[i][j+1]),
                .b_out    (b_d[i+1][j]),
                .a_vld_out(a_v[i][j+1]),
                .acc      (acc_all[i][j])
            );
            // The cell's pair flag also feeds the cell below it.
            assign b_v[i+1][j] = a_v[i][j+1];
        end
    end

endmodule

/* sysarr_control.sv */
module sysarr_control import sys_arr_pkg::*; #(
    parameter int  DW    = DW_DEF,
    parameter int  N     = N_DEF,
    parameter int  DEPTH = DEPTH_DEF,
    localparam int ACC_W = acc_width(DW, N),
    localparam int IW    = $clog2(N)
) (
    input  logic                           clk,
    input  logic                           nRST,
    input  logic                           in_valid,
    input  logic [N-1:0][N-1:0][ACC_W-1:0] acc_all,
    systolic_array_fifo_if.ctrl            a_fifo [N-1:0],
    systolic_array_fifo_if.ctrl            b_fifo [N-1:0],
    output logic                           clear,
    output logic [N-1:0]                   edge_vld,
    output logic                           in_credit,
    output logic                           out_valid,
    output logic [IW-1:0]                  out_index,
    output logic [N-1:0][ACC_W-1:0]        out_row
);

    // The cycle counter must reach 2N-2 in SHIFT and N in DRAIN.
    localparam int CW = $clog2(2 * N);
    localparam int PW = $clog2(DEPTH + 1);

    ctrl_state_t   state;
    logic [IW-1:0] beat_cnt;
    logic [CW-1:0] cyc;
    logic [PW-1:0] pend;
    logic          pair_done;
    logic          start;
    logic [N-1:0]  win;

    // The beat index picks the lane pair; the last beat completes a pair.
    assign pair_done = in_valid && (beat_cnt == IW'(N - 1));
    assign start     = (state == IDLE) && ((pend != '0) || pair_done);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            beat_cnt <= '0;
        end else if (in_valid) begin
            beat_cnt <= pair_done ? '0 : beat_cnt + 1'b1;
        end
    end

    // Pairs stored in the FIFOs but not yet started.
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            pend <= '0;
        end else if (pair_done && !start) begin
            pend <= pend + 1'b1;
        end else if (!pair_done && start) begin
            pend <= pend - 1'b1;
        end
    end

    // cyc restarts at zero on every state change.
    // SHIFT runs 2N-1 cycles, DRAIN N+1 and READOUT N.
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            cyc       <= '0;
            in_credit <= 1'b0;
        end else begin
            // One credit per pair, the cycle after the final shift.
            in_credit <= (state == SHIFT) && (cyc == CW'(2 * N - 2));
            cyc       <= cyc + 1'b1;
            case (state)
                IDLE: begin
                    cyc <= '0;
                    if (start) begin
                        state <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (cyc == CW'(2 * N - 2)) begin
                        state <= DRAIN;
                        cyc   <= '0;
                    end
                end
                DRAIN: begin
                    if (cyc == CW'(N)) begin
                        state <= READOUT;
                        cyc   <= '0;
                    end
                end
                READOUT: begin
                    if (cyc == CW'(N - 1)) begin
                        state <= IDLE;
                        cyc   <= '0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Lane k shifts in SHIFT cycles k to k+N-1, which gives the diagonal skew.
    for (genvar k = 0; k < N; k++) begin : g_lane
        assign win[k]          = (state == SHIFT) && (cyc >= CW'(k)) && (cyc < CW'(k + N));
        assign a_fifo[k].shift = win[k];
        assign b_fifo[k].shift = win[k];
        assign a_fifo[k].load  = in_valid && (beat_cnt == IW'(k));
        assign b_fifo[k].load  = in_valid && (beat_cnt == IW'(k));
        // An edge word counts only if both lanes really present data.
        assign edge_vld[k]     = win[k] & a_fifo[k].valid & b_fifo[k].valid;
    end

    // The accumulators are zeroed in the first SHIFT cycle.
    assign clear = (state == SHIFT) && (cyc == '0);

    // Readout: one row of C per cycle.
    assign out_valid = (state == READOUT);
    assign out_index = cyc[IW-1:0];
    assign out_row   = acc_all[cyc[IW-1:0]];

endmodule

/* sysarr_top.sv */
module sysarr_top import sys_arr_pkg::*; #(
    parameter int  DW    = DW_DEF,
    parameter int  N     = N_DEF,
    parameter int  DEPTH = DEPTH_DEF,
    localparam int ACC_W = acc_width(DW, N)
) (
    input  logic                    clk,
    input  logic                    nRST,
    input  logic                    in_valid,
    input  logic [N*DW-1:0]         in_a_row,
    input  logic [N*DW-1:0]         in_b_col,
    output logic                    in_credit,
    output logic                    out_valid,
    output logic [$clog2(N)-1:0]    out_index,
    output logic [N-1:0][ACC_W-1:0] out_row
);

    logic                           clear;
    logic [N-1:0]                   edge_vld;
    logic [N-1:0][DW-1:0]           a_edge;
    logic [N-1:0][DW-1:0]           b_edge;
    logic [N-1:0][N-1:0][ACC_W-1:0] acc_all;

    // One link per lane for each operand bank.
    systolic_array_fifo_if #(.DW(DW), .N(N)) a_if [N-1:0] ();
    systolic_array_fifo_if #(.DW(DW), .N(N)) b_if [N-1:0] ();

    // Every lane sees the beat; the controller's load picks the one that stores it.
    // The presented FIFO words form the left and top edges of the grid.
    for (genvar k = 0; k < N; k++) begin : g_lane
        assign a_if[k].load_values = in_a_row;
        assign b_if[k].load_values = in_b_col;
        assign a_edge[k]           = a_if[k].out;
        assign b_edge[k]           = b_if[k].out;

        sysarr_fifo #(.DW(DW), .N(N), .DEPTH(DEPTH)) u_a_fifo (
            .clk (clk),
            .nRST(nRST),
            .fifo(a_if[k])
        );

        sysarr_fifo #(.DW(DW), .N(N), .DEPTH(DEPTH)) u_b_fifo (
            .clk (clk),
            .nRST(nRST),
            .fifo(b_if[k])
        );
    end

    sysarr_control #(.DW(DW), .N(N), .DEPTH(DEPTH)) u_ctrl (
        .clk      (clk),
        .nRST     (nRST),
        .in_valid (in_valid),
        .acc_all  (acc_all),
        .a_fifo   (a_if),
        .b_fifo   (b_if),
        .clear    (clear),
        .edge_vld (edge_vld),
        .in_credit(in_credit),
        .out_valid(out_valid),
        .out_index(out_index),
        .out_row  (out_row)
    );

    // A and B lanes k shift together, so one flag vector serves both edges.
    sysarr_array #(.DW(DW), .N(N)) u_array (
        .clk       (clk),
        .nRST      (nRST),
        .clear     (clear),
        .a_edge    (a_edge),
        .a_edge_vld(edge_vld),
        .b_edge    (b_edge),
        .b_edge_vld(edge_vld),
        .acc_all   (acc_all)
    );

endmodule

/* sysarr_tb.sv */
module sysarr_tb import sys_arr_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DW    = DW_DEF;
    localparam int N     = N_DEF;
    localparam int DEPTH = DEPTH_DEF;
    localparam int ACC_W = acc_width(DW, N);
    localparam int IW    = $clog2(N);
    localparam int NT    = 5;
    // Run budget in ns, the reset check and the credit total counted as two more tests.
    localparam int TIME_LIMIT = (NT + 2) * (4 * N + 10) * 20;

    typedef logic [N-1:0][ACC_W-1:0] row_t;
    typedef logic [IW-1:0]           index_t;

    logic            clk;
    logic            nRST;
    logic            in_valid;
    logic [N*DW-1:0] in_a_row;
    logic [N*DW-1:0] in_b_col;
    logic            in_credit;
    logic            out_valid;
    index_t          out_index;
    row_t            out_row;

    // Stimulus table: name, operands, and the expected rows of C.
    // An entry with tab_b2b set follows the previous pair without a gap.
    string         tab_name [NT];
    bit            tab_b2b  [NT];
    logic [DW-1:0] tab_a    [NT][N][N];
    logic [DW-1:0] tab_b    [NT][N][N];
    row_t          tab_c    [NT][N];

    int err_cnt    = 0;
    int pass_cnt   = 0;
    int fail_cnt   = 0;
    int edge_cnt   = 0;
    int done_cnt   = 0;
    int credits_rx = 0;
    int spent      = 0;
    int row_cnt    = 0;
    int row_base   = 0;
    int last_cnt   [NT];

    sysarr_top UUT (
        .clk      (clk),
        .nRST     (nRST),
        .in_valid (in_valid),
        .in_a_row (in_a_row),
        .in_b_col (in_b_col),
        .in_credit(in_credit),
        .out_valid(out_valid),
        .out_index(out_index),
        .out_row  (out_row)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Rising edges are counted so that the readout latency can be measured.
    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic check_row(input string name, input int r, input row_t exp, input row_t act);
        if (act !== exp) begin
            $display("Fail %s row %0d: expected %h, actual %h", name, r, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_index(input string name, input index_t exp, input index_t act);
        if (act !== exp) begin
            $display("Fail %s out_index: expected %0d, actual %0d", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_credits(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Fail %s credits: expected %0d, actual %0d", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Fail %s latency: expected %0d, actual %0d", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int base);
        if (err_cnt == base) begin
            $display("%s: ok", name);
            pass_cnt++;
        end else begin
            $display("%s: %0d mismatches", name, err_cnt - base);
            fail_cnt++;
        end
    endtask

    // Row i of C, where C[i][j] is the unsigned sum over k of A[i][k] * B[k][j].
    function automatic row_t model_row(input int t, input int i);
        row_t r;
        r = '0;
        for (int j = 0; j < N; j++) begin
            for (int k = 0; k < N; k++) begin
                r[j] = r[j] + ACC_W'(tab_a[t][i][k]) * ACC_W'(tab_b[t][k][j]);
            end
        end
        return r;
    endfunction

    task automatic fill_table();
        tab_name = '{"ident_x_rand", "rand_x_ident", "all_max", "rand_pair_1", "rand_pair_2"};
        tab_b2b  = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
        for (int t = 0; t < NT; t++) begin
            for (int i = 0; i < N; i++) begin
                for (int j = 0; j < N; j++) begin
                    tab_a[t][i][j] = DW'($urandom());
                    tab_b[t][i][j] = DW'($urandom());
                end
            end
        end
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                // Identity on one side hands back the other operand unchanged.
                tab_a[0][i][j] = DW'(i == j);
                tab_b[1][i][j] = DW'(i == j);
                tab_c[0][i][j] = ACC_W'(tab_b[0][i][j]);
                tab_c[1][i][j] = ACC_W'(tab_a[1][i][j]);
                // Largest operands; each element is N times the largest product.
                tab_a[2][i][j] = '1;
                tab_b[2][i][j] = '1;
                tab_c[2][i][j] = ACC_W'(N * (2**DW - 1) * (2**DW - 1));
            end
            tab_c[3][i] = model_row(3, i);
            tab_c[4][i] = model_row(4, i);
        end
    endtask

    // Holds while no credit is left; credits_rx is the count returned so far.
    task automatic wait_credit();
        while (DEPTH - spent + credits_rx < 1) begin
            @(negedge clk);
        end
    endtask

    // Beat b carries row b of A and column b of B, element k at bits [k*DW +: DW].
    task automatic send_pair(input int t);
        for (int b = 0; b < N; b++) begin
            in_valid = 1'b1;
            for (int k = 0; k < N; k++) begin
                in_a_row[k*DW +: DW] = tab_a[t][b][k];
                in_b_col[k*DW +: DW] = tab_b[t][k][b];
            end
            if (b == 0) begin
                spent++;
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
        // This is the edge count right after the last beat was sampled.
        last_cnt[t] = edge_cnt;
    endtask

    // Result monitor, sampling at the falling edge where outputs are settled.
    always @(negedge clk) begin
        if (in_credit) begin
            credits_rx <= credits_rx + 1;
        end
        if (out_valid && done_cnt >= NT) begin
            $display("A result row appeared after the last expected product");
            err_cnt++;
        end else if (out_valid) begin
            if (row_cnt == 0) begin
                row_base = err_cnt;
                // Latency only holds when the array was idle before the pair.
                if (!tab_b2b[done_cnt]) begin
                    check_latency(tab_name[done_cnt], 3 * N, edge_cnt - last_cnt[done_cnt]);
                end
            end
            check_index(tab_name[done_cnt], index_t'(row_cnt), out_index);
            check_row(tab_name[done_cnt], row_cnt, tab_c[done_cnt][row_cnt], out_row);
            if (row_cnt == N - 1) begin
                // The credit of this pair arrives before its readout, the next one after.
                check_credits(tab_name[done_cnt], done_cnt + 1, credits_rx);
                report_test(tab_name[done_cnt], row_base);
                row_cnt = 0;
                done_cnt <= done_cnt + 1;
            end else begin
                row_cnt++;
            end
        end else if (row_cnt != 0) begin
            // The N rows of one product come in consecutive cycles.
            $display("%s: out_valid went low after %0d of %0d result rows",
                     tab_name[done_cnt], row_cnt, N);
            err_cnt++;
            row_cnt = 0;
        end
    end

    initial begin
        int base;
        void'($urandom(32'he022));
        nRST     = 1'b0;
        in_valid = 1'b0;
        in_a_row = '0;
        in_b_col = '0;
        fill_table();
        repeat (5) @(negedge clk);
        nRST = 1'b1;

        // No strobe may appear before the first beat.
        base = err_cnt;
        repeat (3 * N) begin
            @(negedge clk);
            if (out_valid || in_credit) begin
                $display("reset_quiet: an output strobe went high before any beat was sent");
                err_cnt++;
            end
        end
        report_test("reset_quiet", base);

        for (int t = 0; t < NT; t++) begin
            if (!tab_b2b[t]) begin
                while (done_cnt != t) begin
                    @(negedge clk);
                end
            end
            wait_credit();
            send_pair(t);
        end
        while (done_cnt != NT) begin
            @(negedge clk);
        end
        repeat (N) @(negedge clk);
        base = err_cnt;
        check_credits("credit_total", NT, credits_rx);
        report_test("credit_total", base);

        $display("%0d tests: %0d passed, %0d failed, %0d errors",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(TIME_LIMIT);
        $display("Watchdog: the run did not finish within %0d ns", TIME_LIMIT);
        $display("Test failed");
        $finish;
    end

endmodule

/* compile.f */
sys_arr_pkg.sv
systolic_array_fifo_if.sv
sysarr_fifo.sv
sysarr_pe.sv
sysarr_array.sv
sysarr_control.sv
sysarr_top.sv
sysarr_tb.sv

/* Makefile */
# Verilator flow for the systolic matrix multiplier.
# Any variable below can be overridden on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= compile.f
TOP       ?= sysarr_tb
LINT_TOP  ?= sysarr_top
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# The run fails unless the log holds the pass line on its own.
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
